//--- design/mixer_pkg.sv
/*
 * Shared constants and payload types for the timed frequency shifter.
 * Imported by every design module that needs widths, addresses or the arctangent table.
 */
package mixer_pkg;

  // ~~~~~~~~~~~~~~ Widths and depths ~~~~~~~~~~~~~~
  localparam int SAMPLE_W       = 16;  // I or Q at the ports.
  localparam int CORDIC_W       = 20;  // Internal component width.
  localparam int PHASE_ACC_W    = 32;  // Phase accumulator and frequency word.
  localparam int PHASE_W        = 16;  // Phase bits that steer the rotation.
  localparam int SCALE_W        = 16;  // Unsigned, Q1.15.
  localparam int SCALE_FRAC     = 15;
  localparam int N_STAGES       = 16;
  localparam int TIME_W         = 32;
  localparam int IN_FIFO_DEPTH  = 8;
  localparam int OUT_FIFO_DEPTH = 8;
  localparam int CMD_FIFO_DEPTH = 4;

  // Counters and product width.
  localparam int SLOT_CNT_W   = $clog2(OUT_FIFO_DEPTH + 1);
  localparam int OUT_CREDIT_W = 8;
  localparam int PROD_W       = CORDIC_W + SCALE_W + 1;

  localparam logic signed [PROD_W-1:0] HALF_LSB = 1 <<< (SCALE_FRAC - 1);
  localparam int SAT_MAX = 2 ** (SAMPLE_W - 1) - 1;
  localparam int SAT_MIN = -(2 ** (SAMPLE_W - 1));

  // Reciprocal of the CORDIC gain in Q1.15, giving unit gain.
  localparam logic [SCALE_W-1:0] SCALE_DEFAULT = 16'h4DBA;

  // ~~~~~~~~~~~~~~ Settings bus ~~~~~~~~~~~~~~~~~~~
  localparam int SR_AW = 8;
  localparam int SR_DW = 32;
  localparam logic [SR_AW-1:0] SR_FREQ_ADDR  = 8'd0;
  localparam logic [SR_AW-1:0] SR_SCALE_ADDR = 8'd1;

  // atan(2^-k) with a full turn equal to 2^16.
  localparam logic [PHASE_W-1:0] ATAN_TABLE [N_STAGES] = '{
    16'd8192, 16'd4836, 16'd2555, 16'd1297, 16'd651, 16'd326, 16'd163, 16'd81,
    16'd41,   16'd20,   16'd10,   16'd5,    16'd3,   16'd1,   16'd1,   16'd0
  };

  // ~~~~~~~~~~~~~~ Payloads ~~~~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    logic signed [SAMPLE_W-1:0] i;
    logic signed [SAMPLE_W-1:0] q;
  } iq_t;

  typedef struct packed {
    logic [TIME_W-1:0]      cmd_time;  // Sample time at which the word applies.
    logic [PHASE_ACC_W-1:0] freq;
  } timed_cmd_t;

endpackage

//--- design/credit_fifo.sv
/*
 * Circular buffer with a type parameter for the payload.
 * The head entry is visible combinationally; pushes when full and pops when empty are ignored.
 */
module credit_fifo #(
  parameter type payload_t = logic [31:0],
  parameter int  DEPTH     = 4
) (
  input  logic     clk,
  input  logic     i_arst_n,
  input  logic     i_push,
  input  payload_t i_data,
  input  logic     i_pop,
  output payload_t o_data,
  output logic     o_empty,
  output logic     o_full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  assign o_empty = (count_q == '0);
  assign o_full  = (count_q == CNT_W'(DEPTH));
  assign do_push = i_push && !o_full;
  assign do_pop  = i_pop && !o_empty;
  assign o_data  = mem_q[rd_ptr_q];  // Head entry.

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= i_data;
    end
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

//--- design/timed_cmd_queue.sv
/*
 * Settings bus decoder with the untimed frequency and scale registers.
 * Timed frequency writes wait in a small queue until the feed takes them.
 */
module timed_cmd_queue
  import mixer_pkg::*;
(
  input  logic                   clk,
  input  logic                   i_arst_n,
  input  logic                   i_set_stb,
  input  logic [SR_AW-1:0]       i_set_addr,
  input  logic [SR_DW-1:0]       i_set_data,
  input  logic [TIME_W-1:0]      i_set_time,
  input  logic                   i_set_has_time,
  input  logic                   i_timed_take,
  output logic [PHASE_ACC_W-1:0] o_freq_word,
  output logic [SCALE_W-1:0]     o_scale,
  output logic                   o_timed_valid,
  output logic [TIME_W-1:0]      o_timed_time,
  output logic [PHASE_ACC_W-1:0] o_timed_freq
);

  logic       freq_wr;
  logic       timed_wr;
  logic       scale_wr;
  logic       cmd_empty;
  logic       cmd_full;
  timed_cmd_t cmd_in;
  timed_cmd_t cmd_head;

  assign freq_wr  = i_set_stb && (i_set_addr == SR_FREQ_ADDR) && !i_set_has_time;
  assign timed_wr = i_set_stb && (i_set_addr == SR_FREQ_ADDR) && i_set_has_time;
  assign scale_wr = i_set_stb && (i_set_addr == SR_SCALE_ADDR);  // Scale is never timed.

  assign cmd_in.cmd_time = i_set_time;
  assign cmd_in.freq     = i_set_data[PHASE_ACC_W-1:0];

  credit_fifo #(
    .payload_t (timed_cmd_t),
    .DEPTH     (CMD_FIFO_DEPTH)
  ) i_cmd_fifo (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_push   (timed_wr && !cmd_full),  // Dropped when the queue is full.
    .i_data   (cmd_in),
    .i_pop    (i_timed_take),
    .o_data   (cmd_head),
    .o_empty  (cmd_empty),
    .o_full   (cmd_full)
  );

  assign o_timed_valid = !cmd_empty;
  assign o_timed_time  = cmd_head.cmd_time;
  assign o_timed_freq  = cmd_head.freq;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_freq_word <= '0;
      o_scale     <= SCALE_DEFAULT;
    end else begin
      // A fresh untimed write wins over a head taken in the same cycle.
      if (freq_wr) begin
        o_freq_word <= i_set_data[PHASE_ACC_W-1:0];
      end else if (i_timed_take) begin
        o_freq_word <= cmd_head.freq;  // Timed word persists.
      end
      if (scale_wr) begin
        o_scale <= i_set_data[SCALE_W-1:0];
      end
    end
  end

endmodule

//--- design/rotator_feed.sv
/*
 * Front end of the rotator. Buffers input samples, returns input credits,
 * runs the sample-time counter and the NCO, and pre-rotates each sample
 * into the +/-90 degree range of the CORDIC stages.
 */
module rotator_feed
  import mixer_pkg::*;
(
  input  logic                       clk,
  input  logic                       i_arst_n,
  input  logic                       i_in_valid,
  input  logic signed [SAMPLE_W-1:0] i_in_i,
  input  logic signed [SAMPLE_W-1:0] i_in_q,
  output logic                       o_in_credit,
  input  logic                       i_slot_freed,
  input  logic [PHASE_ACC_W-1:0]     i_freq_word,
  input  logic                       i_timed_valid,
  input  logic [TIME_W-1:0]          i_timed_time,
  input  logic [PHASE_ACC_W-1:0]     i_timed_freq,
  output logic                       o_timed_take,
  output logic                       o_valid,
  output logic signed [CORDIC_W-1:0] o_x,
  output logic signed [CORDIC_W-1:0] o_y,
  output logic signed [CORDIC_W-1:0] o_z
);

  iq_t                       in_data;
  iq_t                       in_head;
  logic                      in_empty;
  logic                      issue;
  logic                      use_timed;
  logic [SLOT_CNT_W-1:0]     slot_cnt_q;
  logic [TIME_W-1:0]         time_q;
  logic [PHASE_ACC_W-1:0]    phase_q;
  logic [PHASE_ACC_W-1:0]    inc;
  logic [PHASE_W-1:0]        phase_top;
  logic [PHASE_W-1:0]        resid;
  logic                      flip;
  logic signed [CORDIC_W-1:0] ext_x;
  logic signed [CORDIC_W-1:0] ext_y;

  assign in_data.i = i_in_i;
  assign in_data.q = i_in_q;

  credit_fifo #(
    .payload_t (iq_t),
    .DEPTH     (IN_FIFO_DEPTH)
  ) i_in_fifo (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_push   (i_in_valid),  // Never refused under the credit rule.
    .i_data   (in_data),
    .i_pop    (issue),
    .o_data   (in_head),
    .o_empty  (in_empty),
    .o_full   ()
  );

  // ~~~~~~~~~~~~~~ Issue and NCO ~~~~~~~~~~~~~~~~~~~~
  assign issue        = !in_empty && (slot_cnt_q != '0);  // Output slot reserved.
  assign use_timed    = i_timed_valid && (i_timed_time <= time_q);
  assign inc          = use_timed ? i_timed_freq : i_freq_word;
  assign o_timed_take = issue && use_timed;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      slot_cnt_q  <= SLOT_CNT_W'(OUT_FIFO_DEPTH);
      time_q      <= '0;
      phase_q     <= '0;
      o_in_credit <= 1'b0;
      o_valid     <= 1'b0;
    end else begin
      if (i_slot_freed && !issue) begin
        slot_cnt_q <= slot_cnt_q + 1'b1;
      end else if (issue && !i_slot_freed) begin
        slot_cnt_q <= slot_cnt_q - 1'b1;
      end
      if (issue) begin
        time_q  <= time_q + 1'b1;
        phase_q <= phase_q + inc;  // p(t+1) = p(t) + inc(t).
      end
      o_in_credit <= issue;
      o_valid     <= issue;
    end
  end

  // ~~~~~~~~~~~~~~ Pre-rotation ~~~~~~~~~~~~~~~~~~~~~
  // Quadrants 01 and 10 are turned by 180 degrees first.
  assign phase_top = phase_q[PHASE_ACC_W-1 -: PHASE_W];
  assign flip      = phase_top[PHASE_W-1] ^ phase_top[PHASE_W-2];
  assign resid     = flip ? (phase_top ^ {1'b1, {(PHASE_W-1){1'b0}}}) : phase_top;
  assign ext_x     = {{(CORDIC_W-SAMPLE_W){in_head.i[SAMPLE_W-1]}}, in_head.i};
  assign ext_y     = {{(CORDIC_W-SAMPLE_W){in_head.q[SAMPLE_W-1]}}, in_head.q};

  always_ff @(posedge clk) begin
    if (issue) begin
      o_x <= flip ? -ext_x : ext_x;
      o_y <= flip ? -ext_y : ext_y;
      o_z <= {{(CORDIC_W-PHASE_W){resid[PHASE_W-1]}}, resid};  // Residual phase.
    end
  end

endmodule

//--- design/cordic_stage.sv
/*
 * One registered CORDIC micro-rotation at iteration STAGE.
 * Steers the residual phase toward zero; shifts truncate.
 */
module cordic_stage
  import mixer_pkg::*;
#(
  parameter int STAGE = 0
) (
  input  logic                       clk,
  input  logic                       i_arst_n,
  input  logic                       i_valid,
  input  logic signed [CORDIC_W-1:0] i_x,
  input  logic signed [CORDIC_W-1:0] i_y,
  input  logic signed [CORDIC_W-1:0] i_z,
  output logic                       o_valid,
  output logic signed [CORDIC_W-1:0] o_x,
  output logic signed [CORDIC_W-1:0] o_y,
  output logic signed [CORDIC_W-1:0] o_z
);

  logic signed [CORDIC_W-1:0] x_sh;
  logic signed [CORDIC_W-1:0] y_sh;
  logic signed [CORDIC_W-1:0] angle;

  assign x_sh  = i_x >>> STAGE;
  assign y_sh  = i_y >>> STAGE;
  assign angle = {{(CORDIC_W-PHASE_W){1'b0}}, ATAN_TABLE[STAGE]};  // Always positive.

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= i_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (!i_z[CORDIC_W-1]) begin
      // Positive residual, turn counterclockwise.
      o_x <= i_x - y_sh;
      o_y <= i_y + x_sh;
      o_z <= i_z - angle;
    end else begin
      o_x <= i_x + y_sh;
      o_y <= i_y - x_sh;
      o_z <= i_z + angle;
    end
  end

endmodule

//--- design/rotator_drain.sv
/*
 * Back end of the rotator. Applies the gain correction, rounds and clips
 * to SAMPLE_W, buffers the result and sends it against output credits.
 */
module rotator_drain
  import mixer_pkg::*;
(
  input  logic                       clk,
  input  logic                       i_arst_n,
  input  logic                       i_valid,
  input  logic signed [CORDIC_W-1:0] i_x,
  input  logic signed [CORDIC_W-1:0] i_y,
  input  logic [SCALE_W-1:0]         i_scale,
  output logic                       o_slot_freed,
  input  logic                       i_out_credit,
  output logic                       o_out_valid,
  output logic signed [SAMPLE_W-1:0] o_out_i,
  output logic signed [SAMPLE_W-1:0] o_out_q
);

  logic                     prod_valid_q;
  logic signed [PROD_W-1:0] prod_i_q;
  logic signed [PROD_W-1:0] prod_q_q;
  logic [OUT_CREDIT_W-1:0]  credit_q;
  logic                     out_empty;
  logic                     send;
  iq_t                      result;
  iq_t                      out_head;

  // Round half up at bit SCALE_FRAC, then saturate.
  function automatic logic signed [SAMPLE_W-1:0] round_clip(
    input logic signed [PROD_W-1:0] p
  );
    logic signed [PROD_W-1:0] r;
    r = (p + HALF_LSB) >>> SCALE_FRAC;
    if (r > SAT_MAX) begin
      r = SAT_MAX;
    end else if (r < SAT_MIN) begin
      r = SAT_MIN;
    end
    return r[SAMPLE_W-1:0];
  endfunction

  // ~~~~~~~~~~~~~~ Scale ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    prod_i_q <= i_x * $signed({1'b0, i_scale});  // Scale is unsigned Q1.15.
    prod_q_q <= i_y * $signed({1'b0, i_scale});
  end

  assign result.i = round_clip(prod_i_q);
  assign result.q = round_clip(prod_q_q);

  credit_fifo #(
    .payload_t (iq_t),
    .DEPTH     (OUT_FIFO_DEPTH)
  ) i_out_fifo (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_push   (prod_valid_q),  // Slot was reserved by the feed.
    .i_data   (result),
    .i_pop    (send),
    .o_data   (out_head),
    .o_empty  (out_empty),
    .o_full   ()
  );

  // ~~~~~~~~~~~~~~ Output credits ~~~~~~~~~~~~~~~~~~~
  assign send         = !out_empty && (credit_q != '0);
  assign o_slot_freed = send;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      prod_valid_q <= 1'b0;
      credit_q     <= '0;
      o_out_valid  <= 1'b0;
    end else begin
      prod_valid_q <= i_valid;
      if (i_out_credit && !send) begin
        credit_q <= credit_q + 1'b1;
      end else if (send && !i_out_credit) begin
        credit_q <= credit_q - 1'b1;
      end
      o_out_valid <= send;
    end
  end

  always_ff @(posedge clk) begin
    if (send) begin
      o_out_i <= out_head.i;
      o_out_q <= out_head.q;
    end
  end

endmodule

//--- design/timed_freq_mixer.sv
/*
 * Timed frequency shifter top level.
 * Settings queue, rotator feed, chain of CORDIC stages and output drain.
 */
module timed_freq_mixer
  import mixer_pkg::*;
(
  input  logic                       clk,
  input  logic                       i_arst_n,
  input  logic                       i_set_stb,
  input  logic [SR_AW-1:0]           i_set_addr,
  input  logic [SR_DW-1:0]           i_set_data,
  input  logic [TIME_W-1:0]          i_set_time,
  input  logic                       i_set_has_time,
  input  logic                       i_in_valid,
  input  logic signed [SAMPLE_W-1:0] i_in_i,
  input  logic signed [SAMPLE_W-1:0] i_in_q,
  output logic                       o_in_credit,
  input  logic                       i_out_credit,
  output logic                       o_out_valid,
  output logic signed [SAMPLE_W-1:0] o_out_i,
  output logic signed [SAMPLE_W-1:0] o_out_q
);

  logic [PHASE_ACC_W-1:0]     freq_word;
  logic [SCALE_W-1:0]         scale;
  logic                       timed_valid;
  logic [TIME_W-1:0]          timed_time;
  logic [PHASE_ACC_W-1:0]     timed_freq;
  logic                       timed_take;
  logic                       slot_freed;
  logic                       stg_valid [N_STAGES+1];
  logic signed [CORDIC_W-1:0] stg_x [N_STAGES+1];
  logic signed [CORDIC_W-1:0] stg_y [N_STAGES+1];
  logic signed [CORDIC_W-1:0] stg_z [N_STAGES+1];

  timed_cmd_queue i_cmd_queue (
    .clk            (clk),
    .i_arst_n       (i_arst_n),
    .i_set_stb      (i_set_stb),
    .i_set_addr     (i_set_addr),
    .i_set_data     (i_set_data),
    .i_set_time     (i_set_time),
    .i_set_has_time (i_set_has_time),
    .i_timed_take   (timed_take),
    .o_freq_word    (freq_word),
    .o_scale        (scale),
    .o_timed_valid  (timed_valid),
    .o_timed_time   (timed_time),
    .o_timed_freq   (timed_freq)
  );

  rotator_feed i_feed (
    .clk           (clk),
    .i_arst_n      (i_arst_n),
    .i_in_valid    (i_in_valid),
    .i_in_i        (i_in_i),
    .i_in_q        (i_in_q),
    .o_in_credit   (o_in_credit),
    .i_slot_freed  (slot_freed),
    .i_freq_word   (freq_word),
    .i_timed_valid (timed_valid),
    .i_timed_time  (timed_time),
    .i_timed_freq  (timed_freq),
    .o_timed_take  (timed_take),
    .o_valid       (stg_valid[0]),
    .o_x           (stg_x[0]),
    .o_y           (stg_y[0]),
    .o_z           (stg_z[0])
  );

  // ~~~~~~~~~~~~~~ CORDIC chain ~~~~~~~~~~~~~~~~~~~~~
  for (genvar k = 0; k < N_STAGES; k++) begin : g_stage
    cordic_stage #(
      .STAGE (k)
    ) i_stage (
      .clk      (clk),
      .i_arst_n (i_arst_n),
      .i_valid  (stg_valid[k]),
      .i_x      (stg_x[k]),
      .i_y      (stg_y[k]),
      .i_z      (stg_z[k]),
      .o_valid  (stg_valid[k+1]),
      .o_x      (stg_x[k+1]),
      .o_y      (stg_y[k+1]),
      .o_z      (stg_z[k+1])
    );
  end

  rotator_drain i_drain (
    .clk          (clk),
    .i_arst_n     (i_arst_n),
    .i_valid      (stg_valid[N_STAGES]),
    .i_x          (stg_x[N_STAGES]),
    .i_y          (stg_y[N_STAGES]),
    .i_scale      (scale),
    .o_slot_freed (slot_freed),
    .i_out_credit (i_out_credit),
    .o_out_valid  (o_out_valid),
    .o_out_i      (o_out_i),
    .o_out_q      (o_out_q)
  );

endmodule

//--- testbench/tb_timed_freq_mixer.sv
/*
 * Testbench for the timed frequency shifter. Streams random I/Q samples against
 * credits, models the NCO, timed commands and CORDIC bit for bit, and compares every output.
 */
module tb_timed_freq_mixer
  import mixer_pkg::*;
;

  localparam logic [31:0] RAND_SEED = 32'he6e2_e69d;
  localparam int N_T1 = 32;
  localparam int N_T2 = 64;
  localparam int N_T3 = 40;
  localparam int N_T4 = 16;
  localparam int N_T5 = 100;
  localparam int N_T6 = 16;
  localparam int TOTAL_SAMPLES = N_T1 + N_T2 + N_T3 + N_T4 + N_T5 + N_T6;
  localparam int CYCLE_LIMIT   = TOTAL_SAMPLES * 40 + 1000;

  logic                       clk;
  logic                       i_arst_n;
  logic                       i_set_stb;
  logic [SR_AW-1:0]           i_set_addr;
  logic [SR_DW-1:0]           i_set_data;
  logic [TIME_W-1:0]          i_set_time;
  logic                       i_set_has_time;
  logic                       i_in_valid;
  logic signed [SAMPLE_W-1:0] i_in_i;
  logic signed [SAMPLE_W-1:0] i_in_q;
  logic                       o_in_credit;
  logic                       i_out_credit = 1'b0;
  logic                       o_out_valid;
  logic signed [SAMPLE_W-1:0] o_out_i;
  logic signed [SAMPLE_W-1:0] o_out_q;

  // Model state.
  logic [PHASE_ACC_W-1:0] m_phase;
  logic [PHASE_ACC_W-1:0] m_freq;
  logic [SCALE_W-1:0]     m_scale;
  logic [TIME_W-1:0]      m_time;
  timed_cmd_t             m_cmds [$];
  iq_t                    exp_q [$];

  int  n_sent;
  int  n_returned;
  int  n_given;
  int  n_received;
  int  n_errors;
  int  n_pass;
  int  n_fail;
  int  n_cycles;
  bit  credit_gaps;
  logic [31:0] rnd;

  timed_freq_mixer i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ~~~~~~~~~~~~~~ Reference model ~~~~~~~~~~~~~~~~~
  function automatic iq_t expected_rotation(input int si, input int sq,
                                            input logic [PHASE_W-1:0] ph,
                                            input logic [SCALE_W-1:0] sc);
    logic [PHASE_W-1:0] resid;
    logic               swap;
    int                 x;
    int                 y;
    int                 z;
    int                 xs;
    int                 ys;
    longint             r [2];
    iq_t                res;
    swap  = ph[PHASE_W-1] ^ ph[PHASE_W-2];  // Quadrants 01 and 10 turn by half a circle.
    resid = swap ? (ph ^ 16'h8000) : ph;
    x     = swap ? -si : si;
    y     = swap ? -sq : sq;
    z     = $signed(resid);
    for (int k = 0; k < N_STAGES; k++) begin
      xs = x >>> k;
      ys = y >>> k;
      if (z >= 0) begin
        x = x - ys;
        y = y + xs;
        z = z - int'(ATAN_TABLE[k]);
      end else begin
        x = x + ys;
        y = y - xs;
        z = z + int'(ATAN_TABLE[k]);
      end
    end
    r[0] = (longint'(x) * longint'(sc) + 16384) >>> 15;  // Q1.15 scale, round half up.
    r[1] = (longint'(y) * longint'(sc) + 16384) >>> 15;
    for (int n = 0; n < 2; n++) begin
      if (r[n] > 32767) r[n] = 32767;
      if (r[n] < -32768) r[n] = -32768;
    end
    res.i = r[0][SAMPLE_W-1:0];
    res.q = r[1][SAMPLE_W-1:0];
    return res;
  endfunction

  // Advances the NCO model by one issued sample.
  task automatic model_issue(input logic signed [SAMPLE_W-1:0] si,
                             input logic signed [SAMPLE_W-1:0] sq);
    logic [PHASE_ACC_W-1:0] inc;
    inc = m_freq;
    if (m_cmds.size() > 0 && m_cmds[0].cmd_time <= m_time) begin
      inc    = m_cmds[0].freq;
      m_freq = inc;  // Timed word persists.
      void'(m_cmds.pop_front());
    end
    exp_q.push_back(expected_rotation(int'(si), int'(sq), m_phase[PHASE_ACC_W-1 -: PHASE_W],
                                      m_scale));
    m_phase = m_phase + inc;
    m_time  = m_time + 1;
  endtask

  // ~~~~~~~~~~~~~~ Stimulus tasks ~~~~~~~~~~~~~~~~~~
  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      i_in_valid <= 1'b0;
    end
  endtask

  task automatic send_sample(input logic signed [SAMPLE_W-1:0] si,
                             input logic signed [SAMPLE_W-1:0] sq);
    @(posedge clk);
    while (n_sent - n_returned >= IN_FIFO_DEPTH) begin
      i_in_valid <= 1'b0;  // No credit left.
      @(posedge clk);
    end
    i_in_valid <= 1'b1;
    i_in_i     <= si;
    i_in_q     <= sq;
    n_sent++;
    model_issue(si, sq);
  endtask

  task automatic send_random(input int n, input bit gaps);
    for (int k = 0; k < n; k++) begin
      rnd = $urandom;
      send_sample(rnd[15:0], rnd[31:16]);
      if (gaps && $urandom_range(3, 0) == 0) idle($urandom_range(4, 1));
    end
    idle(1);
  endtask

  task automatic write_setting(input logic [SR_AW-1:0] addr, input logic [SR_DW-1:0] data,
                               input logic has_time, input logic [TIME_W-1:0] at_time);
    timed_cmd_t cmd;
    cmd.cmd_time = at_time;
    cmd.freq     = data;
    @(posedge clk);
    i_set_stb      <= 1'b1;
    i_set_addr     <= addr;
    i_set_data     <= data;
    i_set_time     <= at_time;
    i_set_has_time <= has_time;
    if (addr == SR_SCALE_ADDR) begin
      m_scale = data[SCALE_W-1:0];
    end else if (has_time) begin
      if (m_cmds.size() < CMD_FIFO_DEPTH) m_cmds.push_back(cmd);  // Full queue drops it.
    end else begin
      m_freq = data;
    end
    @(posedge clk);
    i_set_stb      <= 1'b0;
    i_set_has_time <= 1'b0;
  endtask

  task automatic wait_drain();
    while (n_received < n_sent) @(posedge clk);
    repeat (3) @(posedge clk);
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (n_errors == errs_before) begin
      $display("Test %s: passed", name);
      n_pass++;
    end else begin
      $display("Test %s: failed with %0d errors", name, n_errors - errs_before);
      n_fail++;
    end
  endtask

  // ~~~~~~~~~~~~~~ Credits, compare, watchdog ~~~~~~
  always @(posedge clk) begin
    if (!i_arst_n) begin
      i_out_credit <= 1'b0;
    end else if (n_given - n_received < OUT_FIFO_DEPTH &&
                 (!credit_gaps || $urandom_range(2, 0) == 0)) begin
      i_out_credit <= 1'b1;
      n_given++;
    end else begin
      i_out_credit <= 1'b0;
    end
  end

  always @(negedge clk) begin
    iq_t exp;
    if (o_in_credit) n_returned++;
    if (n_returned > n_sent) begin
      $display("Input credits held by the sender rose above %0d at %0t", IN_FIFO_DEPTH, $time);
      n_errors++;
    end
    if (o_out_valid) begin
      if (n_received >= n_given) begin
        $display("Output sample at %0t was sent without an output credit", $time);
        n_errors++;
      end
      if (exp_q.size() == 0) begin
        $display("Output sample at %0t arrived with nothing expected", $time);
        n_errors++;
      end else begin
        exp = exp_q.pop_front();
        if (o_out_i !== exp.i || o_out_q !== exp.q) begin
          $display("Error at %0t: sample %0d expected (%0d, %0d) got (%0d, %0d)",
                   $time, n_received, exp.i, exp.q, o_out_i, o_out_q);
          n_errors++;
        end
      end
      n_received++;
    end
  end

  always @(posedge clk) begin
    n_cycles++;
    if (n_cycles >= CYCLE_LIMIT) begin
      $display("Run stopped after %0d cycles without finishing", CYCLE_LIMIT);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // ~~~~~~~~~~~~~~ Test sequence ~~~~~~~~~~~~~~~~~~~
  initial begin
    int errs;
    logic [TIME_W-1:0] t0;
    rnd = $urandom(RAND_SEED);
    i_arst_n = 1'b0;
    i_set_stb = 1'b0;
    i_set_addr = '0;
    i_set_data = '0;
    i_set_time = '0;
    i_set_has_time = 1'b0;
    i_in_valid = 1'b0;
    i_in_i = '0;
    i_in_q = '0;
    m_phase = '0;
    m_freq = '0;
    m_scale = SCALE_DEFAULT;
    m_time = '0;
    credit_gaps = 1'b0;
    repeat (5) @(posedge clk);
    i_arst_n <= 1'b1;
    idle(2);

    errs = n_errors;  // Frequency 0, default scale.
    send_random(N_T1, 1'b0);
    wait_drain();
    report_test("1 identity", errs);

    errs = n_errors;
    write_setting(SR_FREQ_ADDR, 32'h0123_4567, 1'b0, '0);
    send_random(N_T2, 1'b0);
    wait_drain();
    report_test("2 untimed frequency", errs);

    errs = n_errors;
    write_setting(SR_FREQ_ADDR, 32'hF3A0_1234, 1'b1, m_time + 20);
    send_random(N_T3, 1'b0);
    wait_drain();
    report_test("3 timed frequency", errs);

    errs = n_errors;  // Stream paused at m_time.
    t0 = m_time;
    write_setting(SR_FREQ_ADDR, 32'h0800_0000, 1'b1, t0 - 5);
    write_setting(SR_FREQ_ADDR, 32'h1111_1111, 1'b1, t0 + 3);
    write_setting(SR_FREQ_ADDR, 32'h2222_2222, 1'b1, t0 + 6);
    write_setting(SR_FREQ_ADDR, 32'h3333_3333, 1'b1, t0 + 9);
    write_setting(SR_FREQ_ADDR, 32'h7777_0000, 1'b1, t0 + 2);  // Queue already full.
    idle(2);
    send_random(N_T4, 1'b0);
    wait_drain();
    report_test("4 late and dropped commands", errs);

    errs = n_errors;
    credit_gaps = 1'b1;
    send_random(N_T5, 1'b1);
    wait_drain();
    credit_gaps = 1'b0;
    if (n_returned != n_sent) begin
      $display("Input credits returned (%0d) differ from samples sent (%0d)",
               n_returned, n_sent);
      n_errors++;
    end
    report_test("5 credit gaps", errs);

    errs = n_errors;
    write_setting(SR_SCALE_ADDR, 32'h0000_FFFF, 1'b0, '0);
    send_sample(16'sd32767, -16'sd32768);
    for (int k = 1; k < N_T6; k++) begin
      rnd = $urandom;
      send_sample({rnd[15], 1'b1, rnd[13:0]} ^ {1'b0, {15{rnd[15]}}},
                  {rnd[31], 1'b1, rnd[29:16]} ^ {1'b0, {15{rnd[31]}}});
    end
    idle(1);
    wait_drain();
    report_test("6 clipping", errs);

    $display("Tests passed: %0d, failed: %0d", n_pass, n_fail);
    if (n_fail == 0 && n_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- flist.f
design/mixer_pkg.sv
design/credit_fifo.sv
design/timed_cmd_queue.sv
design/rotator_feed.sv
design/cordic_stage.sv
design/rotator_drain.sv
design/timed_freq_mixer.sv
testbench/tb_timed_freq_mixer.sv

//--- Bender.yml
package:
  name: timed_freq_mixer

sources:
  - files:
      - design/mixer_pkg.sv
      - design/credit_fifo.sv
      - design/timed_cmd_queue.sv
      - design/rotator_feed.sv
      - design/cordic_stage.sv
      - design/rotator_drain.sv
      - design/timed_freq_mixer.sv
  - target: simulation
    files:
      - testbench/tb_timed_freq_mixer.sv
